/* source/am_lock_pkg.sv */
package am_lock_pkg;

	localparam int N_PCS_LANES = 20;	// pcs lanes of a 100G link

	typedef logic [65:0] block_t;	// sync header in 65:64, byte 0 in 63:56
	typedef logic [N_PCS_LANES-1:0] lane_mask_t;	// one bit per pcs lane
	typedef logic [4:0] lane_id_t;	// lane number 0..19
	typedef logic [13:0] am_period_t;	// valid blocks between two markers
	typedef logic [23:0] am_code_t;	// M0 M1 M2 of one marker

	localparam logic [1:0] AM_SYNC = 2'b10;	// markers travel as control blocks

	// marker bytes M0, M1, M2 for lanes 0..19
	// M4..M6 on the wire carry the inverse of these, M3/M7 are the BIP bytes
	localparam am_code_t am_code_table [N_PCS_LANES] = '{
		24'hC1_68_21,	// lane 0
		24'h9D_71_8E,
		24'h59_4B_E8,
		24'h4D_95_7B,
		24'hF5_07_09,
		24'hDD_14_C2,	// lane 5
		24'h9A_4A_26,
		24'h7B_45_66,
		24'hA0_24_76,
		24'h68_C9_FB,
		24'hFD_6C_99,	// lane 10
		24'hB9_91_55,
		24'h5C_B9_B2,
		24'h1A_F8_BD,
		24'h83_C7_CA,
		24'h35_36_CD,	// lane 15
		24'hC4_31_4C,
		24'hAD_D6_B7,
		24'h5F_66_2A,
		24'hC0_F0_E5	// lane 19
	};

	// am lock states, one per bubble of the lock diagram
	typedef enum logic [1:0]
	{
		INIT,
		WAIT_1ST,
		WAIT_2ND,
		LOCKED
	} am_state_t;

endpackage

/* source/am_comparator.sv */
module am_comparator
	import am_lock_pkg::*;
(
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_valid,	// one block per strobe
	input  block_t     i_block,
	input  lane_mask_t i_match_mask,	// lanes the fsm still accepts
	output block_t     o_block,
	output logic       o_valid,
	output lane_mask_t o_match_vector,	// every lane that matched, unmasked
	output logic       o_am_valid	// marker of an accepted lane
);

	logic [1:0] sync_hdr;
	am_code_t   code_bytes;	// bytes 0..2
	am_code_t   inv_bytes;	// bytes 4..6
	lane_mask_t match_vector;
	logic       any_accepted;

	// split the block, BIP3 (byte 3) and BIP7 (byte 7) are skipped
	assign sync_hdr   = i_block[65:64];
	assign code_bytes = i_block[63:40];
	assign inv_bytes  = i_block[31:8];

	// all 20 lanes checked in parallel
	always_comb
	begin
		for (int k = 0; k < N_PCS_LANES; k++)
		begin
			match_vector[k] = (sync_hdr == AM_SYNC)
				&& (code_bytes == am_code_table[k])
				&& (inv_bytes == ~am_code_table[k]);	// second half is the inverse
		end
	end

	assign any_accepted = |(match_vector & i_match_mask);

	// block and match vector are plain pipeline data
	always_ff @(posedge i_clock)
	begin
		o_block        <= i_block;
		o_match_vector <= match_vector;
	end

	// strobe and decision travel together with the block
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_valid    <= 1'b0;
			o_am_valid <= 1'b0;
		end
		else
		begin
			o_valid    <= i_valid;
			o_am_valid <= i_valid && any_accepted;	// idle cycles never flag a marker
		end
	end

	// the 20 codes differ enough that a block can only ever hit one lane
	a_single_lane_match : assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_valid |-> $onehot0(o_match_vector)
	) else $error("am_comparator: block matched more than one lane");

endmodule

/* source/am_lock_fsm.sv */
module am_lock_fsm
	import am_lock_pkg::*;
#(
	parameter int MAX_VALID_AM   = 20,
	parameter int MAX_INVALID_AM = 8
)
(
	input  logic                                  i_clock,
	input  logic                                  i_reset,
	input  logic                                  i_enable,	// lane in use
	input  logic                                  i_valid,	// delayed block strobe
	input  logic                                  i_block_lock,
	input  logic                                  i_am_valid,
	input  lane_mask_t                            i_match_vector,
	input  logic [$clog2(MAX_VALID_AM + 1)-1:0]   i_lock_thr,
	input  logic [$clog2(MAX_INVALID_AM + 1)-1:0] i_unlock_thr,
	input  am_period_t                            i_am_period,
	output lane_mask_t                            o_match_mask,
	output logic                                  o_am_lock,	// lock as of the next clock
	output logic                                  o_start_of_lane,
	output logic                                  o_resync
);

	localparam int NB_VALID_CNT   = $clog2(MAX_VALID_AM + 1);
	localparam int NB_INVALID_CNT = $clog2(MAX_INVALID_AM + 1);

	am_state_t                 state;
	am_state_t                 state_next;
	lane_mask_t                match_mask;
	lane_mask_t                match_mask_next;
	logic [NB_VALID_CNT-1:0]   valid_count;	// good markers at expiry, in a row
	logic [NB_INVALID_CNT-1:0] invalid_count;	// missing markers while locked
	am_period_t                search_timer;	// marker spacing from the last hit
	am_period_t                lane_timer;	// start-of-lane spacing from lock
	logic                      first_lock_done;
	logic                      step;
	logic                      search_done;
	logic                      lane_done;
	logic                      restart_search;
	logic                      lock_event;

	assign step        = i_valid && i_enable;	// everything moves one block at a time
	assign search_done = (search_timer >= i_am_period);
	assign lane_done   = (lane_timer >= i_am_period);

	// next state and mask
	always_comb
	begin
		state_next      = state;
		match_mask_next = match_mask;
		restart_search  = 1'b0;
		lock_event      = 1'b0;
		if (!i_block_lock)
		begin
			state_next      = INIT;	// block lock lost so start over
			match_mask_next = '1;
		end
		else if (step)
		begin
			unique case (state)
				INIT:
				begin
					state_next      = WAIT_1ST;
					match_mask_next = '1;
				end
				WAIT_1ST:
				begin
					if (i_am_valid)
					begin
						restart_search  = 1'b1;	// spacing counts from this marker
						match_mask_next = i_match_vector;	// follow this lane only
						state_next      = WAIT_2ND;
					end
				end
				WAIT_2ND:
				begin
					if (search_done && !i_am_valid)
					begin
						state_next      = WAIT_1ST;	// wrong spacing means a new search
						match_mask_next = '1;
					end
					else if (search_done && (valid_count == i_lock_thr))
					begin
						state_next = LOCKED;
						lock_event = 1'b1;
					end
				end
				LOCKED:
				begin
					if (search_done && !i_am_valid && (invalid_count == i_unlock_thr))
					begin
						state_next      = WAIT_1ST;	// too many misses
						match_mask_next = '1;
					end
				end
				default:
				begin
					state_next = INIT;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state      <= INIT;
			match_mask <= '1;
		end
		else
		begin
			state      <= state_next;
			match_mask <= match_mask_next;
		end
	end

	// counts only during the confirmation phase
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			valid_count <= '0;
		else if (step)
		begin
			if (state != WAIT_2ND)
				valid_count <= '0;
			else if (search_done)
				valid_count <= i_am_valid ? valid_count + 1'b1 : '0;
		end
	end

	// a good marker leaves the miss count alone and only a new lock clears it
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			invalid_count <= '0;
		else if (step)
		begin
			if (lock_event)
				invalid_count <= '0;
			else if ((state == LOCKED) && search_done && !i_am_valid)
				invalid_count <= invalid_count + 1'b1;
		end
	end

	// both timers run 1..period and wrap
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			search_timer    <= am_period_t'(1);
			lane_timer      <= am_period_t'(1);
			first_lock_done <= 1'b0;
		end
		else if (step)
		begin
			search_timer <= (restart_search || search_done) ? am_period_t'(1)
				: search_timer + 1'b1;
			lane_timer   <= (lock_event || lane_done) ? am_period_t'(1)
				: lane_timer + 1'b1;	// free running once locked
			if (lock_event)
				first_lock_done <= 1'b1;
		end
	end

	assign o_match_mask    = match_mask;
	assign o_am_lock       = (state_next == LOCKED);
	assign o_start_of_lane = step && (state == LOCKED) && lane_done;
	// offset moved if the lane timer is not at its end when the marker locks
	assign o_resync        = lock_event && (!first_lock_done || (lane_timer != search_timer));

	a_locked_single_lane : assert property (
		@(posedge i_clock) disable iff (i_reset)
		(state == LOCKED) |-> $onehot(match_mask)
	) else $error("am_lock_fsm: locked without a one-hot lane mask");

	// the flag leads LOCKED only on the marker that completes the lock
	a_lock_means_locked : assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_am_lock |-> (state == LOCKED) || ((state == WAIT_2ND) && i_am_valid)
	) else $error("am_lock_fsm: lock flag raised outside LOCKED");

endmodule

/* source/am_lane_output.sv */
module am_lane_output
	import am_lock_pkg::*;
(
	input  logic       i_clock,
	input  logic       i_reset,
	input  logic       i_valid,
	input  block_t     i_block,
	input  logic       i_am_valid,	// block is a marker of the locked lane
	input  logic       i_am_lock,
	input  lane_mask_t i_match_mask,
	input  logic       i_start_of_lane,
	input  logic       i_resync,
	output block_t     o_block,
	output logic       o_block_valid,
	output logic       o_am_lock,
	output lane_id_t   o_lane_id,
	output logic       o_start_of_lane,
	output logic       o_resync
);

	lane_id_t lane_enc;
	logic     drop_marker;

	// one-hot mask to lane number
	always_comb
	begin
		lane_enc = '0;
		for (int k = 0; k < N_PCS_LANES; k++)
		begin
			if (i_match_mask[k])
				lane_enc = lane_id_t'(k);
		end
	end

	assign drop_marker = i_am_lock && i_am_valid;	// unlocked, markers pass as data

	always_ff @(posedge i_clock)
	begin
		o_block <= i_block;	// data is qualified by the strobe
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_block_valid   <= 1'b0;
			o_am_lock       <= 1'b0;
			o_lane_id       <= '0;
			o_start_of_lane <= 1'b0;
			o_resync        <= 1'b0;
		end
		else
		begin
			o_block_valid   <= i_valid && !drop_marker;
			o_am_lock       <= i_am_lock;
			o_start_of_lane <= i_start_of_lane;
			o_resync        <= i_resync;
			if (i_am_lock)
				o_lane_id <= lane_enc;	// last lane stays visible after unlock
		end
	end

endmodule

/* source/am_lock_lane.sv */
module am_lock_lane
	import am_lock_pkg::*;
#(
	parameter int MAX_VALID_AM   = 20,
	parameter int MAX_INVALID_AM = 8
)
(
	input  logic                                  i_clock,
	input  logic                                  i_reset,
	input  logic                                  i_valid,
	input  logic                                  i_enable,
	input  logic                                  i_block_lock,
	input  block_t                                i_block,
	input  logic [$clog2(MAX_VALID_AM + 1)-1:0]   i_lock_thr,	// extra good markers for lock
	input  logic [$clog2(MAX_INVALID_AM + 1)-1:0] i_unlock_thr,	// misses tolerated
	input  am_period_t                            i_am_period,
	output block_t                                o_block,
	output logic                                  o_block_valid,
	output logic                                  o_am_lock,
	output lane_id_t                              o_lane_id,
	output logic                                  o_start_of_lane,
	output logic                                  o_resync
);

	block_t     blk;	// block one cycle after input
	logic       blk_valid;
	lane_mask_t match_vector;
	logic       am_valid;
	lane_mask_t match_mask;
	logic       am_lock;
	logic       start_of_lane;
	logic       resync;

	// marker detection, adds the first cycle
	am_comparator u_am_comparator (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_block        (i_block),
		.i_match_mask   (match_mask),
		.o_block        (blk),
		.o_valid        (blk_valid),
		.o_match_vector (match_vector),
		.o_am_valid     (am_valid)
	);

	// lock decision, same cycle as the registered block
	am_lock_fsm #(
		.MAX_VALID_AM   (MAX_VALID_AM),
		.MAX_INVALID_AM (MAX_INVALID_AM)
	) u_am_lock_fsm (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_enable        (i_enable),
		.i_valid         (blk_valid),
		.i_block_lock    (i_block_lock),
		.i_am_valid      (am_valid),
		.i_match_vector  (match_vector),
		.i_lock_thr      (i_lock_thr),
		.i_unlock_thr    (i_unlock_thr),
		.i_am_period     (i_am_period),
		.o_match_mask    (match_mask),
		.o_am_lock       (am_lock),
		.o_start_of_lane (start_of_lane),
		.o_resync        (resync)
	);

	// marker removal and lane report, second cycle
	am_lane_output u_am_lane_output (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_valid         (blk_valid),
		.i_block         (blk),
		.i_am_valid      (am_valid),
		.i_am_lock       (am_lock),
		.i_match_mask    (match_mask),
		.i_start_of_lane (start_of_lane),
		.i_resync        (resync),
		.o_block         (o_block),
		.o_block_valid   (o_block_valid),
		.o_am_lock       (o_am_lock),
		.o_lane_id       (o_lane_id),
		.o_start_of_lane (o_start_of_lane),
		.o_resync        (o_resync)
	);

endmodule

/* verification/tb_am_lock_lane.sv */
module tb_am_lock_lane
	import am_lock_pkg::*;
;

	localparam int MAX_VALID_AM   = 20;
	localparam int MAX_INVALID_AM = 8;
	localparam int AM_PERIOD      = 16;	// valid blocks between markers
	localparam int DRIVE_DELAY    = 10;	// inputs change this long after the rising edge
	localparam int SAMPLE_DELAY   = 20;
	localparam int MK_PASS        = 0;	// marker sent and still forwarded
	localparam int MK_DROP        = 1;	// marker sent and removed while locked
	localparam int MK_MISS        = 2;	// data block in the marker slot

	logic                                  i_clock;
	logic                                  i_reset;
	logic                                  i_valid;
	logic                                  i_enable;
	logic                                  i_block_lock;
	block_t                                i_block;
	logic [$clog2(MAX_VALID_AM + 1)-1:0]   i_lock_thr;
	logic [$clog2(MAX_INVALID_AM + 1)-1:0] i_unlock_thr;
	am_period_t                            i_am_period;
	block_t                                o_block;
	logic                                  o_block_valid;
	logic                                  o_am_lock;
	lane_id_t                              o_lane_id;
	logic                                  o_start_of_lane;
	logic                                  o_resync;

	logic [15:0] lfsr_state;
	block_t      ref_q[$];	// blocks expected on o_block in order
	int          sol_slots[$];	// block index of each start-of-lane pulse
	logic [1:0]  valid_hist;	// input strobe two cycles back
	logic        slot_valid;
	logic        lock_prev;
	int          sent_count;	// valid blocks driven so far
	int          slot_count;	// valid blocks that reached the output side
	int          resync_count;
	int          resync_slot;
	int          lock_rise_slot;
	int          lock_fall_slot;

	am_lock_lane #(
		.MAX_VALID_AM   (MAX_VALID_AM),
		.MAX_INVALID_AM (MAX_INVALID_AM)
	) u_am_lock_lane (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_valid         (i_valid),
		.i_enable        (i_enable),
		.i_block_lock    (i_block_lock),
		.i_block         (i_block),
		.i_lock_thr      (i_lock_thr),
		.i_unlock_thr    (i_unlock_thr),
		.i_am_period     (i_am_period),
		.o_block         (o_block),
		.o_block_valid   (o_block_valid),
		.o_am_lock       (o_am_lock),
		.o_lane_id       (o_lane_id),
		.o_start_of_lane (o_start_of_lane),
		.o_resync        (o_resync)
	);

	always #50 i_clock = ~i_clock;

	// 16 bit galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [63:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);	// one step per bit
			bits[i]    = lfsr_state[0];
		end
	endtask

	task automatic make_data(output block_t b);
		logic [63:0] payload;
		random_bits(64, payload);
		b = {2'b01, payload};	// data header never looks like a marker
	endtask

	task automatic make_marker(input int lane, output block_t b);
		logic [63:0] bip;
		random_bits(16, bip);	// bip bytes are noise here
		b = {AM_SYNC, am_code_table[lane], bip[7:0], ~am_code_table[lane], bip[15:8]};
	endtask

	task stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task report_problem(input string msg);
		$display("%s (time %0t)", msg, $time);
		stop_run();
	endtask

	task compare_block(input block_t act, input block_t exp, input string what);
		if (act !== exp)
		begin
			$display("Fail at %0t: %s expected %h, got %h", $time, what, exp, act);
			stop_run();
		end
	endtask

	task compare_lane(input lane_id_t act, input lane_id_t exp, input string what);
		if (act !== exp)
		begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, what, exp, act);
			stop_run();
		end
	endtask

	task compare_flag(input logic act, input logic exp, input string what);
		if (act !== exp)
		begin
			$display("Fail at %0t: %s expected %b, got %b", $time, what, exp, act);
			stop_run();
		end
	endtask

	task compare_count(input int act, input int exp, input string what);
		if (act != exp)
		begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, what, exp, act);
			stop_run();
		end
	endtask

	task automatic drive_block(input block_t b, input logic forward);
		@(posedge i_clock);
		#DRIVE_DELAY;
		i_valid = 1'b1;
		i_block = b;
		if (forward)
			ref_q.push_back(b);	// should come out unchanged
		sent_count++;
	endtask

	task automatic drive_idle(input int n);
		repeat (n)
		begin
			@(posedge i_clock);
			#DRIVE_DELAY;
			i_valid = 1'b0;
		end
	endtask

	task automatic send_data(input int n);
		block_t b;
		repeat (n)
		begin
			make_data(b);
			drive_block(b, 1'b1);
		end
	endtask

	// marker slot plus 15 data blocks with gap idle cycles after each block
	task automatic send_period(input int lane, input int mode, input int gap);
		block_t b;
		if (mode == MK_MISS)
			make_data(b);
		else
			make_marker(lane, b);
		drive_block(b, mode != MK_DROP);
		drive_idle(gap);
		repeat (AM_PERIOD - 1)
		begin
			make_data(b);
			drive_block(b, 1'b1);
			drive_idle(gap);
		end
	endtask

	// stop the stream and wait until every sent block has passed the output
	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		drive_idle(1);
		while ((ref_q.size() != 0) || (slot_count != sent_count))
		begin
			@(posedge i_clock);
			#SAMPLE_DELAY;
			cycles++;
			if (cycles > limit)
				report_problem("timeout: forwarded blocks did not all arrive on o_block");
		end
	endtask

	task automatic wait_for_lock(input logic level, input int limit);
		int cycles;
		cycles = 0;
		drive_idle(1);
		while (o_am_lock !== level)
		begin
			@(posedge i_clock);
			#SAMPLE_DELAY;
			cycles++;
			if (cycles > limit)
				report_problem("timeout: o_am_lock never reached the expected level");
		end
	endtask

	// output side sampled mid cycle two cycles behind the input
	always @(negedge i_clock)
	begin
		slot_valid = valid_hist[1];
		valid_hist = {valid_hist[0], i_valid};
		if (!i_reset)
		begin
			if (o_block_valid)
			begin
				if (!slot_valid || (ref_q.size() == 0))
					report_problem("o_block_valid set where no block was expected");
				else
					compare_block(o_block, ref_q.pop_front(), "o_block");
			end
			if (o_start_of_lane)
				sol_slots.push_back(slot_count);
			if (o_resync)
			begin
				resync_count++;
				resync_slot = slot_count;
			end
			if (o_am_lock && !lock_prev)
				lock_rise_slot = slot_count;
			if (!o_am_lock && lock_prev)
				lock_fall_slot = slot_count;
			lock_prev = o_am_lock;
			if (slot_valid)
				slot_count++;
		end
	end

	task automatic check_reset_values();
		@(posedge i_clock);
		#SAMPLE_DELAY;
		compare_flag(o_am_lock, 1'b0, "o_am_lock after reset");
		compare_flag(o_block_valid, 1'b0, "o_block_valid after reset");
		compare_flag(o_start_of_lane, 1'b0, "o_start_of_lane after reset");
		compare_flag(o_resync, 1'b0, "o_resync after reset");
		compare_lane(o_lane_id, lane_id_t'(0), "o_lane_id after reset");
	endtask

	// lock_thr 2 means four markers and the fourth one is already removed
	task automatic test_acquire();
		int lock_idx;
		int resyncs;
		resyncs = resync_count;
		send_data(3);	// first block only takes the fsm out of INIT
		send_period(7, MK_PASS, 0);
		send_period(7, MK_PASS, 0);
		send_period(7, MK_PASS, 0);
		lock_idx = sent_count;
		send_period(7, MK_DROP, 0);
		wait_for_lock(1'b1, 40);
		wait_drain(40);
		compare_count(lock_rise_slot, lock_idx, "block index of the lock");
		compare_lane(o_lane_id, lane_id_t'(7), "o_lane_id at lock");
		compare_count(resync_count, resyncs + 1, "resync pulses at first lock");
		compare_count(resync_slot, lock_idx, "block index of the resync");
	endtask

	task automatic test_marker_removal();
		send_period(7, MK_DROP, 0);
		send_period(7, MK_DROP, 0);
		wait_drain(40);	// queue holds data only since markers are removed
		compare_flag(o_am_lock, 1'b1, "o_am_lock while markers arrive");
	endtask

	task automatic test_unlock_relock();
		int fall_idx;
		int lock_idx;
		int resyncs;
		send_period(7, MK_MISS, 0);
		send_period(7, MK_MISS, 0);
		fall_idx = sent_count;
		send_period(7, MK_MISS, 0);	// third miss in a row unlocks with unlock_thr 2
		wait_for_lock(1'b0, 40);
		wait_drain(40);
		compare_count(lock_fall_slot, fall_idx, "block index of the unlock");
		resyncs = resync_count;
		send_data(5);	// new marker grid five blocks later
		send_period(7, MK_PASS, 0);
		send_period(7, MK_PASS, 0);
		send_period(7, MK_PASS, 0);
		lock_idx = sent_count;
		send_period(7, MK_DROP, 0);
		wait_for_lock(1'b1, 40);
		wait_drain(40);
		compare_count(lock_rise_slot, lock_idx, "block index of the relock");
		compare_count(resync_count, resyncs + 1, "resync pulses at relock");
		compare_lane(o_lane_id, lane_id_t'(7), "o_lane_id at relock");
	endtask

	task automatic test_start_of_lane();
		int resyncs;
		sol_slots.delete();
		resyncs = resync_count;
		send_period(7, MK_DROP, 0);
		send_period(7, MK_MISS, 0);
		send_period(7, MK_MISS, 1);	// idle cycles between blocks
		send_period(7, MK_DROP, 2);
		wait_drain(40);
		compare_count(sol_slots.size(), 4, "start-of-lane pulses");
		foreach (sol_slots[k])
			compare_count(sol_slots[k], lock_rise_slot + AM_PERIOD * (k + 1),
				"block index of a start-of-lane pulse");
		compare_flag(o_am_lock, 1'b1, "o_am_lock after two misses");
		compare_count(resync_count, resyncs, "resync pulses while locked");
	endtask

	task automatic test_mask_and_block_lock();
		int lock_idx;
		@(posedge i_clock);
		#DRIVE_DELAY;
		i_block_lock = 1'b0;	// block lock lost while locked
		wait_for_lock(1'b0, 10);
		drive_idle(3);
		i_block_lock = 1'b1;
		send_data(2);
		send_period(7, MK_PASS, 0);	// mask narrows to lane 7
		send_period(3, MK_PASS, 0);	// other lane at expiry sends the fsm back to search
		send_period(7, MK_PASS, 0);
		send_period(7, MK_PASS, 0);
		send_period(7, MK_PASS, 0);
		lock_idx = sent_count;
		send_period(7, MK_DROP, 0);
		wait_for_lock(1'b1, 40);
		wait_drain(40);
		compare_count(lock_rise_slot, lock_idx, "block index of the lock after search");
		compare_lane(o_lane_id, lane_id_t'(7), "o_lane_id after search");
	endtask

	initial
	begin
		i_clock        = 1'b0;
		i_reset        = 1'b1;
		i_valid        = 1'b0;
		i_enable       = 1'b1;
		i_block_lock   = 1'b1;
		i_block        = '0;
		i_lock_thr     = 2;
		i_unlock_thr   = 2;
		i_am_period    = am_period_t'(AM_PERIOD);
		lfsr_state     = 16'd71;
		valid_hist     = 2'b00;
		lock_prev      = 1'b0;
		sent_count     = 0;
		slot_count     = 0;
		resync_count   = 0;
		resync_slot    = -1;
		lock_rise_slot = -1;
		lock_fall_slot = -1;
		repeat (5) @(posedge i_clock);
		#DRIVE_DELAY;
		i_reset = 1'b0;
		check_reset_values();
		test_acquire();
		test_marker_removal();
		test_unlock_relock();
		test_start_of_lane();
		test_mask_and_block_lock();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

/* am_lock_lane.f */
source/am_lock_pkg.sv
source/am_comparator.sv
source/am_lock_fsm.sv
source/am_lane_output.sv
source/am_lock_lane.sv
verification/tb_am_lock_lane.sv
